// File: include/render_defines.svh
`ifndef RENDER_DEFINES_SVH
`define RENDER_DEFINES_SVH

`define UNITS_PER_SIDE  2
`define SPRITE_TYPES    4
`define TYPE_STRIDE     128     // rom pixels per sprite type
`define PX_PER_WORD     32      // 2-bit pixels per rom word
`define ROM_WORDS       16
`define SCALE_SHIFT     1       // sprites drawn at 2x

// sprite size per type in image pixels
`define SPRITE0_W       4'd8
`define SPRITE0_H       4'd8
`define SPRITE1_W       4'd8
`define SPRITE1_H       4'd6
`define SPRITE2_W       4'd6
`define SPRITE2_H       4'd8
`define SPRITE3_W       4'd4
`define SPRITE3_H       4'd4

`define SKY_END         10'd140
`define PATH_START      10'd170
`define PATH_END        10'd230
`define BOARD_START     10'd270

`define COLOR_WHITE     12'hfff
`define COLOR_RED       12'hf00
`define COLOR_BLACK     12'h000
`define COLOR_SKY       12'h2bf
`define COLOR_GRASS     12'h5b2
`define COLOR_PATH      12'hda5
`define COLOR_BOARD     12'hfb7

`define LATENCY         3       // scan in to pixel out

`endif

// File: hw/render_pkg.sv
`default_nettype none

package render_pkg;

    // unit word with msb first
    typedef struct packed {
        logic        exist;
        logic [2:0]  kind;          // low 2 bits pick the sprite
        logic [9:0]  x;
        logic [9:0]  y;
        logic [11:0] hp;
        logic [3:0]  state;
        logic [3:0]  state_cnt;
        logic [11:0] damaged;
    } unit_t;

    localparam logic [3:0] ST_WALK   = 4'd0;
    localparam logic [3:0] ST_ATTACK = 4'd1;

    typedef struct packed {
        logic [9:0] h;
        logic [9:0] v;
    } scan_t;

    typedef struct packed {
        logic       hit;
        logic [8:0] addr;   // pixel index into the side's rom
    } sprite_req_t;

    typedef struct packed {
        logic       hit;
        logic [1:0] code;
    } sprite_px_t;

    // rom colour codes
    localparam logic [1:0] CODE_WHITE = 2'd0;
    localparam logic [1:0] CODE_BLACK = 2'd1;
    localparam logic [1:0] CODE_RED   = 2'd2;
    localparam logic [1:0] CODE_TRANS = 2'd3;

endpackage

`default_nettype wire

// File: hw/unit_decode.sv
`default_nettype none
`include "render_defines.svh"

module unit_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  render_pkg::scan_t       scan,
    input  render_pkg::unit_t       army [`UNITS_PER_SIDE],
    input  render_pkg::unit_t       enemy [`UNITS_PER_SIDE],
    output render_pkg::sprite_req_t army_req [`UNITS_PER_SIDE],
    output render_pkg::sprite_req_t enemy_req [`UNITS_PER_SIDE],
    output render_pkg::scan_t       scan_d1
);

    localparam int KIND_BITS = $clog2(`SPRITE_TYPES);

    localparam logic [3:0] SPR_W [`SPRITE_TYPES] = '{`SPRITE0_W, `SPRITE1_W,
                                                    `SPRITE2_W, `SPRITE3_W};
    localparam logic [3:0] SPR_H [`SPRITE_TYPES] = '{`SPRITE0_H, `SPRITE1_H,
                                                    `SPRITE2_H, `SPRITE3_H};

    function automatic render_pkg::sprite_req_t decode_unit(
        input render_pkg::unit_t u,
        input render_pkg::scan_t s
    );
        logic [KIND_BITS-1:0]    kind;
        logic [3:0]              w;
        logic [3:0]              h;
        logic                    frame;
        logic [10:0]             dx;
        logic [10:0]             dy;
        render_pkg::sprite_req_t req;

        kind = u.kind[KIND_BITS-1:0];
        w = SPR_W[kind];
        h = SPR_H[kind];

        case (u.state)
            render_pkg::ST_ATTACK: frame = 1'b1;
            render_pkg::ST_WALK:   frame = 1'b0;
            default:               frame = 1'b0;   // other states show walk
        endcase

        // offsets only meaningful when scan is right of / below the origin
        dx = {1'b0, s.h} - {1'b0, u.x};
        dy = {1'b0, s.v} - {1'b0, u.y};

        req.hit = u.exist
                  && (s.h >= u.x) && (dx < ({7'd0, w} << `SCALE_SHIFT))
                  && (s.v >= u.y) && (dy < ({7'd0, h} << `SCALE_SHIFT));
        req.addr = 9'(kind * `TYPE_STRIDE + frame * w * h
                      + (dy >> `SCALE_SHIFT) * w + (dx >> `SCALE_SHIFT));
        return req;
    endfunction

    genvar i;
    generate
        for (i = 0; i < `UNITS_PER_SIDE; i++) begin : g_lane
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    army_req[i].hit  <= 1'b0;
                    enemy_req[i].hit <= 1'b0;
                end else begin
                    army_req[i]  <= decode_unit(army[i], scan);
                    enemy_req[i] <= decode_unit(enemy[i], scan);
                end
            end
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_d1 <= '0;
        end else begin
            scan_d1 <= scan;    // keeps position aligned with req
        end
    end

endmodule

`default_nettype wire

// File: hw/sprite_fetch.sv
`default_nettype none
`include "render_defines.svh"

module sprite_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  render_pkg::sprite_req_t army_req [`UNITS_PER_SIDE],
    input  render_pkg::sprite_req_t enemy_req [`UNITS_PER_SIDE],
    input  render_pkg::scan_t       scan_d1,
    output render_pkg::sprite_px_t  army_px [`UNITS_PER_SIDE],
    output render_pkg::sprite_px_t  enemy_px [`UNITS_PER_SIDE],
    output render_pkg::scan_t       scan_d2
);

    localparam int WORD_W     = 2 * `PX_PER_WORD;
    localparam int WORD_BITS  = $clog2(`ROM_WORDS);
    localparam int FIELD_BITS = $clog2(`PX_PER_WORD);

    logic [WORD_W-1:0] army_rom  [`ROM_WORDS];
    logic [WORD_W-1:0] enemy_rom [`ROM_WORDS];

    initial begin
        $readmemh("sprites_army.hex", army_rom);
        $readmemh("sprites_enemy.hex", enemy_rom);
    end

    // registered read with one port per lane
    logic [WORD_W-1:0]     army_word   [`UNITS_PER_SIDE];
    logic [WORD_W-1:0]     enemy_word  [`UNITS_PER_SIDE];
    logic [FIELD_BITS-1:0] army_field  [`UNITS_PER_SIDE];
    logic [FIELD_BITS-1:0] enemy_field [`UNITS_PER_SIDE];
    logic                  army_hit    [`UNITS_PER_SIDE];
    logic                  enemy_hit   [`UNITS_PER_SIDE];

    // field 0 sits in the low bits
    function automatic logic [1:0] pick_code(
        input logic [WORD_W-1:0]     word,
        input logic [FIELD_BITS-1:0] field
    );
        return word[{field, 1'b0} +: 2];
    endfunction

    genvar i;
    generate
        for (i = 0; i < `UNITS_PER_SIDE; i++) begin : g_lane
            always_ff @(posedge clk) begin
                army_word[i]   <= army_rom[army_req[i].addr[FIELD_BITS +: WORD_BITS]];
                enemy_word[i]  <= enemy_rom[enemy_req[i].addr[FIELD_BITS +: WORD_BITS]];
                army_field[i]  <= army_req[i].addr[FIELD_BITS-1:0];
                enemy_field[i] <= enemy_req[i].addr[FIELD_BITS-1:0];
                if (!rst_n) begin
                    army_hit[i]  <= 1'b0;
                    enemy_hit[i] <= 1'b0;
                end else begin
                    army_hit[i]  <= army_req[i].hit;
                    enemy_hit[i] <= enemy_req[i].hit;
                end
            end

            assign army_px[i]  = '{hit: army_hit[i],
                                   code: pick_code(army_word[i], army_field[i])};
            assign enemy_px[i] = '{hit: enemy_hit[i],
                                   code: pick_code(enemy_word[i], enemy_field[i])};
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_d2 <= '0;
        end else begin
            scan_d2 <= scan_d1;
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_compose.sv
`default_nettype none
`include "render_defines.svh"

module pixel_compose (
    input  logic                   clk,
    input  logic                   rst_n,
    input  render_pkg::sprite_px_t army_px [`UNITS_PER_SIDE],
    input  render_pkg::sprite_px_t enemy_px [`UNITS_PER_SIDE],
    input  render_pkg::scan_t      scan_d2,
    output logic [11:0]            pixel
);

    localparam int LANES = 2 * `UNITS_PER_SIDE;

    render_pkg::sprite_px_t lane [LANES];   // army lanes first
    logic                   win;
    logic [1:0]             win_code;
    logic [11:0]            pixel_next;

    function automatic logic [11:0] palette(input logic [1:0] code);
        case (code)
            render_pkg::CODE_WHITE: return `COLOR_WHITE;
            render_pkg::CODE_RED:   return `COLOR_RED;
            render_pkg::CODE_BLACK: return `COLOR_BLACK;
            default:                return `COLOR_BLACK;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < `UNITS_PER_SIDE; i++) begin
            lane[i]                   = army_px[i];
            lane[i + `UNITS_PER_SIDE] = enemy_px[i];
        end
    end

    // first opaque hit in lane order wins
    always_comb begin
        win      = 1'b0;
        win_code = render_pkg::CODE_TRANS;
        for (int i = 0; i < LANES; i++) begin
            if (!win && lane[i].hit && lane[i].code != render_pkg::CODE_TRANS) begin
                win      = 1'b1;
                win_code = lane[i].code;
            end
        end
    end

    always_comb begin
        if (scan_d2.v >= `BOARD_START) begin
            pixel_next = `COLOR_BOARD;      // lower half is flat
        end else if (win) begin
            pixel_next = palette(win_code);
        end else if (scan_d2.v >= `PATH_START && scan_d2.v < `PATH_END) begin
            pixel_next = `COLOR_PATH;
        end else if (scan_d2.v >= `SKY_END) begin
            pixel_next = `COLOR_GRASS;
        end else begin
            pixel_next = `COLOR_SKY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel <= '0;
        end else begin
            pixel <= pixel_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/battlefield_render.sv
`default_nettype none
`include "render_defines.svh"

module battlefield_render (
    input  logic              clk,
    input  logic              rst_n,
    input  render_pkg::scan_t scan,
    input  render_pkg::unit_t army [`UNITS_PER_SIDE],
    input  render_pkg::unit_t enemy [`UNITS_PER_SIDE],
    output logic [11:0]       pixel
);

    render_pkg::sprite_req_t army_req  [`UNITS_PER_SIDE];
    render_pkg::sprite_req_t enemy_req [`UNITS_PER_SIDE];
    render_pkg::sprite_px_t  army_px   [`UNITS_PER_SIDE];
    render_pkg::sprite_px_t  enemy_px  [`UNITS_PER_SIDE];
    render_pkg::scan_t       scan_d1;
    render_pkg::scan_t       scan_d2;

    unit_decode unit_decode_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan      (scan),
        .army      (army),
        .enemy     (enemy),
        .army_req  (army_req),
        .enemy_req (enemy_req),
        .scan_d1   (scan_d1)
    );

    sprite_fetch sprite_fetch_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .army_req  (army_req),
        .enemy_req (enemy_req),
        .scan_d1   (scan_d1),
        .army_px   (army_px),
        .enemy_px  (enemy_px),
        .scan_d2   (scan_d2)
    );

    pixel_compose pixel_compose_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .army_px  (army_px),
        .enemy_px (enemy_px),
        .scan_d2  (scan_d2),
        .pixel    (pixel)
    );

endmodule

`default_nettype wire

// File: verification/battlefield_render_props.sv
`default_nettype none
`include "render_defines.svh"

module battlefield_render_props (
    input logic                    clk,
    input logic                    rst_n,
    input render_pkg::scan_t       scan,
    input render_pkg::unit_t       army [`UNITS_PER_SIDE],
    input render_pkg::unit_t       enemy [`UNITS_PER_SIDE],
    input render_pkg::sprite_req_t army_req [`UNITS_PER_SIDE],
    input render_pkg::sprite_req_t enemy_req [`UNITS_PER_SIDE],
    input render_pkg::scan_t       scan_d2,
    input logic [11:0]             pixel
);

    reset_clears_pixel: assert property (@(posedge clk) !rst_n |=> pixel == 12'h000)
        else $error("pixel not cleared by reset");

    genvar i;
    generate
        for (i = 0; i < `UNITS_PER_SIDE; i++) begin : g_lane
            army_hit_needs_exist: assert property (@(posedge clk) disable iff (!rst_n)
                !army[i].exist |=> !army_req[i].hit)
                else $error("army lane %0d hit with exist clear", i);
            enemy_hit_needs_exist: assert property (@(posedge clk) disable iff (!rst_n)
                !enemy[i].exist |=> !enemy_req[i].hit)
                else $error("enemy lane %0d hit with exist clear", i);
        end
    endgenerate

    // two register stages between scan and scan_d2
    scan_two_behind: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && $past(rst_n, 2) |-> scan_d2 == $past(scan, 2))
        else $error("scan_d2 out of step with scan");

endmodule

bind battlefield_render battlefield_render_props props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .scan      (scan),
    .army      (army),
    .enemy     (enemy),
    .army_req  (army_req),
    .enemy_req (enemy_req),
    .scan_d2   (scan_d2),
    .pixel     (pixel)
);

`default_nettype wire

// File: verification/battlefield_render_tb.sv
`default_nettype none
`include "render_defines.svh"

module battlefield_render_tb;

    localparam int RESET_CYCLES = 3;
    localparam int RANDOM_ROWS  = 24;
    localparam int TIMEOUT_SLACK = 20;

    typedef struct packed {
        render_pkg::scan_t scan;
        render_pkg::unit_t army0;
        render_pkg::unit_t army1;
        render_pkg::unit_t enemy0;
        render_pkg::unit_t enemy1;
        logic [11:0]       expected;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    render_pkg::scan_t scan;
    render_pkg::unit_t army  [`UNITS_PER_SIDE];
    render_pkg::unit_t enemy [`UNITS_PER_SIDE];
    logic [11:0]       pixel;

    row_t        row_q [$];
    logic [63:0] army_img  [`ROM_WORDS];    // same images the DUT loads
    logic [63:0] enemy_img [`ROM_WORDS];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    battlefield_render battlefield_render_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .scan  (scan),
        .army  (army),
        .enemy (enemy),
        .pixel (pixel)
    );

    always #4 clk = ~clk;

    function automatic int img_width(input int kind);
        case (kind)
            0:       return `SPRITE0_W;
            1:       return `SPRITE1_W;
            2:       return `SPRITE2_W;
            default: return `SPRITE3_W;
        endcase
    endfunction

    function automatic int img_height(input int kind);
        case (kind)
            0:       return `SPRITE0_H;
            1:       return `SPRITE1_H;
            2:       return `SPRITE2_H;
            default: return `SPRITE3_H;
        endcase
    endfunction

    function automatic logic [11:0] code_color(input logic [1:0] code);
        case (code)
            2'd0:    return `COLOR_WHITE;
            2'd2:    return `COLOR_RED;
            default: return `COLOR_BLACK;
        endcase
    endfunction

    function automatic logic [11:0] band_color(input int v);
        if (v >= `BOARD_START) return `COLOR_BOARD;
        else if (v >= `PATH_START && v < `PATH_END) return `COLOR_PATH;
        else if (v >= `SKY_END) return `COLOR_GRASS;
        else return `COLOR_SKY;
    endfunction

    // {visible, code} for one unit at one scan position
    function automatic logic [2:0] lane_lookup(input render_pkg::unit_t u, input int h,
                                               input int v, input bit army_side);
        int          kind;
        int          w;
        int          ht;
        int          ux;
        int          uy;
        int          p;
        logic [63:0] word;
        logic [1:0]  code;

        kind = int'(u.kind[1:0]);
        w    = img_width(kind);
        ht   = img_height(kind);
        ux   = int'(u.x);
        uy   = int'(u.y);
        if (!u.exist || h < ux || h >= ux + 2 * w || v < uy || v >= uy + 2 * ht) begin
            return 3'b000;
        end
        p = kind * `TYPE_STRIDE + (v - uy) / 2 * w + (h - ux) / 2;
        if (u.state == render_pkg::ST_ATTACK) begin
            p = p + w * ht;     // attack frame follows walk frame
        end
        word = army_side ? army_img[p / `PX_PER_WORD] : enemy_img[p / `PX_PER_WORD];
        code = word[2 * (p % `PX_PER_WORD) +: 2];
        return {code != render_pkg::CODE_TRANS, code};
    endfunction

    function automatic logic [11:0] model_pixel(input row_t r);
        logic [2:0]  vis [4];
        int          h;
        int          v;
        logic [11:0] result;

        h      = int'(r.scan.h);
        v      = int'(r.scan.v);
        vis[0] = lane_lookup(r.army0, h, v, 1'b1);
        vis[1] = lane_lookup(r.army1, h, v, 1'b1);
        vis[2] = lane_lookup(r.enemy0, h, v, 1'b0);
        vis[3] = lane_lookup(r.enemy1, h, v, 1'b0);
        result = band_color(v);
        if (v < `BOARD_START) begin
            for (int i = 3; i >= 0; i--) begin
                if (vis[i][2]) result = code_color(vis[i][1:0]);  // lower lane overwrites
            end
        end
        return result;
    endfunction

    function automatic render_pkg::unit_t make_unit(input bit exist, input int kind,
                                                    input int x, input int y,
                                                    input logic [3:0] state);
        render_pkg::unit_t u;

        u       = '0;
        u.exist = exist;
        u.kind  = 3'(kind);
        u.x     = 10'(x);
        u.y     = 10'(y);
        u.hp    = 12'h064;
        u.state = state;
        return u;
    endfunction

    function automatic render_pkg::unit_t random_unit();
        bit   exist;
        int   kind;
        int   x;
        int   y;
        logic [3:0] state;

        exist = ($urandom % 4) != 0;
        kind  = $urandom % `SPRITE_TYPES;
        x     = 100 + $urandom % 16;
        y     = 100 + $urandom % 16;
        state = 4'($urandom % 2);
        return make_unit(exist, kind, x, y, state);
    endfunction

    task automatic add_row(input int h, input int v, input render_pkg::unit_t a0,
                           input render_pkg::unit_t a1, input render_pkg::unit_t e0,
                           input render_pkg::unit_t e1, input logic [11:0] expected,
                           input bit from_rom);
        row_t r;

        r.scan.h   = 10'(h);
        r.scan.v   = 10'(v);
        r.army0    = a0;
        r.army1    = a1;
        r.enemy0   = e0;
        r.enemy1   = e1;
        r.expected = from_rom ? model_pixel(r) : expected;
        row_q.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        scan     <= r.scan;
        army[0]  <= r.army0;
        army[1]  <= r.army1;
        enemy[0] <= r.enemy0;
        enemy[1] <= r.enemy1;
    endtask

    task automatic check_pixel(input int idx);
        row_t r;

        r = row_q[idx];
        checks++;
        assert (pixel === r.expected) else begin
            errors++;
            $display("CHECK FAILED pixel row %0d at h=%h v=%h: got %h, expected %h",
                     idx, r.scan.h, r.scan.v, pixel, r.expected);
        end
    endtask

    initial begin
        render_pkg::unit_t none;
        render_pkg::unit_t hidden;
        render_pkg::unit_t walk;
        render_pkg::unit_t attack;
        render_pkg::unit_t foe;
        render_pkg::unit_t pick [4];
        int                w;
        int                ht;

        rst_n = 1'b0;
        scan  = '0;
        for (int i = 0; i < `UNITS_PER_SIDE; i++) begin
            army[i]  = '0;
            enemy[i] = '0;
        end
        $readmemh("sprites_army.hex", army_img);
        $readmemh("sprites_enemy.hex", enemy_img);
        void'($urandom(32'h4ab29d55));

        none = make_unit(0, 0, 0, 0, render_pkg::ST_WALK);

        // empty field across the band edges
        add_row(10, 0, none, none, none, none, `COLOR_SKY, 0);
        add_row(10, 139, none, none, none, none, `COLOR_SKY, 0);
        add_row(10, 140, none, none, none, none, `COLOR_GRASS, 0);
        add_row(10, 169, none, none, none, none, `COLOR_GRASS, 0);
        add_row(10, 170, none, none, none, none, `COLOR_PATH, 0);
        add_row(10, 229, none, none, none, none, `COLOR_PATH, 0);
        add_row(10, 230, none, none, none, none, `COLOR_GRASS, 0);
        add_row(10, 269, none, none, none, none, `COLOR_GRASS, 0);
        add_row(10, 270, none, none, none, none, `COLOR_BOARD, 0);
        add_row(639, 479, none, none, none, none, `COLOR_BOARD, 0);

        // each type at its corners and centre and sky just past every edge
        for (int k = 0; k < `SPRITE_TYPES; k++) begin
            walk   = make_unit(1, k, 200, 40, render_pkg::ST_WALK);
            attack = make_unit(1, k, 200, 40, render_pkg::ST_ATTACK);
            w      = img_width(k);
            ht     = img_height(k);
            add_row(200, 40, walk, none, none, none, 12'h000, 1);
            add_row(199 + 2 * w, 39 + 2 * ht, walk, none, none, none, 12'h000, 1);
            add_row(200 + w, 40 + ht, walk, none, none, none, 12'h000, 1);
            add_row(199, 40, walk, none, none, none, `COLOR_SKY, 0);
            add_row(200 + 2 * w, 40 + ht, walk, none, none, none, `COLOR_SKY, 0);
            add_row(200, 39, walk, none, none, none, `COLOR_SKY, 0);
            add_row(200, 40 + 2 * ht, walk, none, none, none, `COLOR_SKY, 0);
            add_row(200, 40, attack, none, none, none, 12'h000, 1);
            add_row(199 + 2 * w, 39 + 2 * ht, attack, none, none, none, 12'h000, 1);
            add_row(200 + w, 40 + ht, attack, none, none, none, 12'h000, 1);
        end

        // type 0 frame 0 against frame 1 and one transparent spot
        walk   = make_unit(1, 0, 100, 100, render_pkg::ST_WALK);
        attack = make_unit(1, 0, 100, 100, render_pkg::ST_ATTACK);
        foe    = make_unit(1, 0, 100, 100, render_pkg::ST_WALK);
        hidden = make_unit(0, 0, 100, 100, render_pkg::ST_WALK);
        add_row(100, 100, walk, none, none, none, `COLOR_RED, 0);
        add_row(100, 100, attack, none, none, none, `COLOR_BLACK, 0);
        add_row(104, 100, walk, none, none, none, `COLOR_SKY, 0);
        add_row(104, 100, attack, none, none, none, `COLOR_BLACK, 0);

        // side and lane priority and the exist bit
        add_row(100, 100, none, none, foe, none, `COLOR_WHITE, 0);
        add_row(100, 100, walk, none, foe, none, `COLOR_RED, 0);
        add_row(104, 100, walk, none, none, foe, `COLOR_WHITE, 0);
        add_row(100, 100, walk, attack, none, none, `COLOR_RED, 0);
        add_row(100, 100, attack, walk, none, none, `COLOR_BLACK, 0);
        add_row(104, 100, walk, attack, none, none, `COLOR_BLACK, 0);
        add_row(100, 100, hidden, attack, none, none, `COLOR_BLACK, 0);
        add_row(100, 100, hidden, hidden, none, none, `COLOR_SKY, 0);
        add_row(100, 100, hidden, none, foe, none, `COLOR_WHITE, 0);

        // random placements near one spot
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            for (int i = 0; i < 4; i++) begin
                pick[i] = random_unit();
            end
            w  = 100 + $urandom % 24;
            ht = 100 + $urandom % 24;
            add_row(w, ht, pick[0], pick[1], pick[2], pick[3], 12'h000, 1);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // one row per cycle and each checked once its pixel is out
        for (int c = 0; c < row_q.size() + `LATENCY; c++) begin
            @(posedge clk);
            if (c < row_q.size()) apply_row(row_q[c]);
            @(negedge clk);
            if (c >= `LATENCY) check_pixel(c - `LATENCY);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > row_q.size() + TIMEOUT_SLACK) begin
            $display("run did not finish within %0d cycles", cycles - 1);
            $display("sim failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sprites_army.hex
// one 64-bit rom word per line, word 0 first
// pixel n of a word sits in bits 2n+1:2n, code 3 is transparent
5555aaaa0000fafa
0a0a5f5faaaa0000
aaaa0000ffff5555
00005555aaaaf0f0
0000aaaa5555fafa
a5a5f0f05a5a0a0a
5555fffa0000aaaa
0f0f0f0f55aa55aa
aaaa55550000ffaf
5a5a5a5a0f0f0f0f
0000ffff5555aaaa
a0a0a0a05f5f5f5f
55aa55aa0000fafa
ffff0000aaaa5555
050505050a0a0a0a
aaaaffff55550000

// File: sprites_enemy.hex
// one 64-bit rom word per line, word 0 first
// pixel n of a word sits in bits 2n+1:2n, code 3 is transparent
5555000055550000
00005555a0a05555
0000aaaa55550000
5a5a00000a0a5555
5555000005050000
0000555555550f0f
00aa00aa55550000
5555555500000000
0000f5f555550000
55550000aaaa0000
0505050500005555
5555a5a500000000
0000555500f00000
5555000055550000
00000000aaaa5555
5555aaaa00000000

// File: vlog.f
+incdir+include
hw/render_pkg.sv
hw/unit_decode.sv
hw/sprite_fetch.sv
hw/pixel_compose.sv
hw/battlefield_render.sv
verification/battlefield_render_props.sv
verification/battlefield_render_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module battlefield_render_tb -f vlog.f -o battlefield_render_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/battlefield_render_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
